// File: dv/if_stimulus.txt
// pc_mux exc_mux irq_id value count ready_pattern first_pc
// value drives boot_addr, branch target, mepc, depc and mtvec, count 0 ends the list
0 0 00 00001000 6 ffffffff 00001080
1 0 00 00004006 5 a5a5a5a5 00004004
3 0 00 00005010 4 33333333 00005010
4 0 00 0000600f 4 ffffffff 0000600c
2 0 00 00002001 4 ffffffff 00002000
2 1 05 00002001 4 f0f0f0f0 00002014
2 2 00 00002001 4 ffffffff 1a110800
2 3 00 00002001 4 5a5a5a5a 1a110808
1 0 00 00002ff8 6 ffffffff 00002ff8
0 0 00 12345678 3 77777777 12345680
0 0 00 00000000 0 00000000 00000000

// File: flist.f
+incdir+include
hdl/if_pkg.sv
hdl/pc_select.sv
hdl/fetch_unit.sv
hdl/if_id_regs.sv
hdl/if_stage_top.sv
dv/tb_if_stage.sv

// File: Makefile
# Verilator build and run for the instruction fetch stage

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_if_stage
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)
PASS_MSG  = Test completed successfully

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_if_stage.sv
/*
  Testbench for the instruction fetch stage
  replays redirect records from a vector file against a bus memory model
*/

`timescale 1ns/1ps

`include "if_params.svh"

module tb_if_stage import if_pkg::*; ();

  localparam int          MAX_RECS  = 16;
  localparam int          REC_WORDS = 7;             // fields per record
  localparam logic [31:0] ERR_LO    = 32'h0000_3000; // bus error window
  localparam logic [31:0] ERR_HI    = 32'h0000_3007;

  logic                clk_i;
  logic                rst_ni;
  logic                instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [`IF_XLEN-1:0] instr_addr_o, instr_rdata_i;
  logic [`IF_XLEN-1:0] boot_addr_i, branch_target_i;
  logic [`IF_XLEN-1:0] csr_mepc_i, csr_depc_i, csr_mtvec_i;
  logic                req_i, pc_set_i;
  pc_sel_e             pc_mux_i;
  exc_pc_sel_e         exc_pc_mux_i;
  logic [4:0]          irq_id_i;
  logic                csr_mtvec_init_o, if_busy_o;
  logic                id_in_ready_i, instr_valid_clear_i;
  logic                instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
  logic [`IF_XLEN-1:0] instr_rdata_id_o, pc_id_o, pc_if_o;

  logic [31:0] stim [0:MAX_RECS*REC_WORDS-1];
  integer      seed         = 56;
  int          errors       = 0;
  int          words_seen   = 0;
  int          limit_cycles = 0;
  int          rsp_left     = 0;  // cycles to the next rvalid
  int          gnt_left     = -1; // grant delay, -1 until drawn
  logic [31:0] rsp_addr;

  if_stage_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic in_err_window(logic [31:0] addr);
    return (addr >= ERR_LO) && (addr <= ERR_HI);
  endfunction

  function automatic logic [31:0] stim_field(int r, int col);
    return stim[7'(r * REC_WORDS + col)];
  endfunction

  task automatic report_mismatch(string name, string what, logic [31:0] exp,
                                 logic [31:0] act);
    errors = errors + 1;
    $display("Error: %s %s expected %h actual %h", name, what, exp, act);
  endtask

  task automatic report_problem(string name, string msg);
    errors = errors + 1;
    $display("Failure in %s: %s", name, msg);
  endtask

  ////////////////////
  // bus memory model
  ////////////////////

  initial begin
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    forever begin
      @(negedge clk_i);
      if (instr_gnt_i) begin
        rsp_left = 1 + int'($unsigned($random(seed)) % 2);
      end
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      if (rsp_left > 0) begin
        rsp_left = rsp_left - 1;
        if (rsp_left == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = ~rsp_addr;  // data is the inverted address
          instr_err_i    = in_err_window(rsp_addr);
        end
      end
      // request on the bus or word still in flight
      if ((instr_req_o || rsp_left > 0) && !if_busy_o)
        report_problem("bus", "if_busy_o low while a request is unanswered");
      if (instr_req_o && instr_addr_o[1:0] != 2'b00)
        report_problem("bus", "instr_addr_o is not word aligned");
      // no new grant while a word is still in flight
      if (rsp_left == 0 && instr_req_o) begin
        if (gnt_left < 0) gnt_left = int'($unsigned($random(seed)) % 3);
        if (gnt_left == 0) begin
          instr_gnt_i = 1'b1;
          rsp_addr    = instr_addr_o;
          gnt_left    = -1;
        end else begin
          gnt_left = gnt_left - 1;
        end
      end
    end
  end

  ////////////////////
  // one redirect record
  ////////////////////

  task automatic run_record(int r);
    logic [31:0] word;
    logic [31:0] exp_pc;
    logic [31:0] last_pc;
    logic [31:0] held_pc;
    logic [31:0] pattern;
    logic [4:0]  cyc;
    logic        stalled;
    int          count;
    int          accepted;
    int          hold;
    string       name;

    name     = $sformatf("record %0d", r);
    count    = int'(stim_field(r, 4));
    pattern  = stim_field(r, 5);
    exp_pc   = stim_field(r, 6);
    hold     = 2 * (r % 4);  // back-pressure cycles after the last word
    cyc      = 5'd0;
    accepted = 0;

    // ready stays high so a held word would be squashed
    word            = stim_field(r, 0);
    pc_mux_i        = pc_sel_e'(word[2:0]);
    word            = stim_field(r, 1);
    exc_pc_mux_i    = exc_pc_sel_e'(word[1:0]);
    word            = stim_field(r, 2);
    irq_id_i        = word[4:0];
    word            = stim_field(r, 3);
    boot_addr_i     = word;
    branch_target_i = word;
    csr_mepc_i      = word;
    csr_depc_i      = word;
    csr_mtvec_i     = word;
    pc_set_i        = 1'b1;
    id_in_ready_i   = 1'b1;
    #10;
    if (csr_mtvec_init_o !== (pc_mux_i == PC_BOOT))
      report_mismatch(name, "csr_mtvec_init_o", 32'(pc_mux_i == PC_BOOT),
                      32'(csr_mtvec_init_o));
    @(negedge clk_i);
    pc_set_i = 1'b0;
    if (instr_valid_id_o || instr_new_id_o)
      report_problem(name, "a word was taken in the redirect cycle");
    last_pc = pc_id_o;

    while (accepted < count) begin
      id_in_ready_i = pattern[cyc];
      stalled       = ~pattern[cyc];
      cyc           = cyc + 5'd1;
      held_pc       = pc_if_o;  // word offered to decode this cycle
      @(negedge clk_i);
      if (csr_mtvec_init_o)
        report_problem(name, "csr_mtvec_init_o high outside the boot redirect");
      if (instr_new_id_o && stalled) begin
        report_problem(name, "instr_new_id_o pulsed while decode was stalled");
      end else if (instr_new_id_o) begin
        if (pc_id_o !== exp_pc)
          report_mismatch(name, "pc_id_o", exp_pc, pc_id_o);
        if (held_pc !== exp_pc)
          report_mismatch(name, "pc_if_o", exp_pc, held_pc);
        if (instr_rdata_id_o !== ~exp_pc)
          report_mismatch(name, "instr_rdata_id_o", ~exp_pc, instr_rdata_id_o);
        if (instr_fetch_err_o !== in_err_window(exp_pc))
          report_mismatch(name, "instr_fetch_err_o", 32'(in_err_window(exp_pc)),
                          32'(instr_fetch_err_o));
        if (!instr_valid_id_o)
          report_problem(name, "instr_valid_id_o low alongside a new word");
        exp_pc     = exp_pc + 32'd4;
        accepted   = accepted + 1;
        words_seen = words_seen + 1;
      end else if (pc_id_o !== last_pc) begin
        report_mismatch(name, "pc_id_o hold", last_pc, pc_id_o);
      end
      last_pc = pc_id_o;
    end

    // decode stalls, valid must hold until cleared
    id_in_ready_i = 1'b0;
    repeat (hold) begin
      @(negedge clk_i);
      if (instr_new_id_o || !instr_valid_id_o || pc_id_o !== last_pc)
        report_problem(name, "IF-ID outputs moved under back-pressure");
    end
    instr_valid_clear_i = 1'b1;
    @(negedge clk_i);
    instr_valid_clear_i = 1'b0;
    if (instr_valid_id_o)
      report_problem(name, "instr_valid_id_o stayed high after the clear");
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int r;

    rst_ni              = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    irq_id_i            = '0;
    boot_addr_i         = '0;
    branch_target_i     = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    csr_mtvec_i         = '0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;

    $readmemh("dv/if_stimulus.txt", stim);
    for (r = 0; r < MAX_RECS && stim_field(r, 4) != 0; r++)
      limit_cycles = limit_cycles + 20 * int'(stim_field(r, 4));

    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    req_i  = 1'b1;
    @(negedge clk_i);
    if (instr_req_o || instr_valid_id_o || instr_new_id_o || instr_fetch_err_o ||
        csr_mtvec_init_o || if_busy_o)
      report_problem("reset", "a control output is high before the first redirect");

    for (r = 0; r < MAX_RECS && stim_field(r, 4) != 0; r++)
      run_record(r);

    $display("%0d words checked, %0d errors", words_seen, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog sized from the record lengths
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

// File: hdl/if_stage_top.sv
/*
  Instruction fetch stage
  next PC selection, bus fetch and the IF-ID register
*/

`timescale 1ns/1ps

`include "if_params.svh"

module if_stage_top import if_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,

  // instruction bus
  output logic                instr_req_o,
  output logic [`IF_XLEN-1:0] instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [`IF_XLEN-1:0] instr_rdata_i,
  input  logic                instr_err_i,

  // control from the core
  input  logic [`IF_XLEN-1:0] boot_addr_i,
  input  logic                req_i,
  input  logic                pc_set_i,
  input  pc_sel_e             pc_mux_i,
  input  exc_pc_sel_e         exc_pc_mux_i,
  input  logic [4:0]          irq_id_i,
  input  logic [`IF_XLEN-1:0] branch_target_i,

  // CSR file
  input  logic [`IF_XLEN-1:0] csr_mepc_i,
  input  logic [`IF_XLEN-1:0] csr_depc_i,
  input  logic [`IF_XLEN-1:0] csr_mtvec_i,
  output logic                csr_mtvec_init_o,

  // decode side
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output logic [`IF_XLEN-1:0] instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output logic [`IF_XLEN-1:0] pc_id_o,
  output logic [`IF_XLEN-1:0] pc_if_o,
  output logic                if_busy_o
);

  redirect_t  redirect;
  logic       fetch_valid;
  logic       fetch_ready;
  fetch_rsp_t fetch_rsp;

  pc_select u_pc_select (
    .boot_addr_i      (boot_addr_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .branch_target_i  (branch_target_i),
    .irq_id_i         (irq_id_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .pc_set_i         (pc_set_i),
    .redirect_o       (redirect),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_unit u_fetch_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .redirect_i     (redirect),
    .ready_i        (fetch_ready),
    .valid_o        (fetch_valid),
    .rsp_o          (fetch_rsp),
    .busy_o         (if_busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  if_id_regs u_if_id_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rsp_i         (fetch_rsp),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o)
  );

  assign pc_if_o = fetch_rsp.addr; // PC of the held word

endmodule

// File: hdl/if_id_regs.sv
/*
  IF-ID pipeline register
  loads accepted fetch words and keeps the valid and new flags
*/

`timescale 1ns/1ps

`include "if_params.svh"

module if_id_regs import if_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_valid_i,
  input  fetch_rsp_t          fetch_rsp_i,
  input  logic                id_in_ready_i,
  input  logic                pc_set_i,
  input  logic                instr_valid_clear_i,
  output logic                fetch_ready_o,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output logic [`IF_XLEN-1:0] instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output logic [`IF_XLEN-1:0] pc_id_o
);

  logic load;
  logic valid_d, valid_q;
  logic new_q;

  // decode takes the word whenever it can
  assign fetch_ready_o = id_in_ready_i;

  // a redirect in the same cycle squashes the word
  assign load = fetch_valid_i & fetch_ready_o & ~pc_set_i;

  // valid holds until decode clears it
  assign valid_d = load | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q           <= 1'b0;
      new_q             <= 1'b0;
      instr_fetch_err_o <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= load;     // one cycle per loaded word
      if (load) begin
        instr_fetch_err_o <= fetch_rsp_i.err;
      end
    end
  end

  // frozen under back-pressure
  always_ff @(posedge clk_i) begin
    if (load) begin
      instr_rdata_id_o <= fetch_rsp_i.rdata;
      pc_id_o          <= fetch_rsp_i.addr;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

// File: hdl/fetch_unit.sv
/*
  Fetch unit
  word fetch bus master with one live request, drops responses
  made stale by a redirect and holds one word for decode
*/

`timescale 1ns/1ps

`include "if_params.svh"

module fetch_unit import if_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  redirect_t           redirect_i,
  input  logic                ready_i,
  output logic                valid_o,
  output fetch_rsp_t          rsp_o,
  output logic                busy_o,
  output logic                instr_req_o,
  output logic [`IF_XLEN-1:0] instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [`IF_XLEN-1:0] instr_rdata_i,
  input  logic                instr_err_i
);

  fetch_state_e        state_q, state_d;
  logic [`IF_XLEN-1:0] addr_q, addr_d;       // address of current request
  logic                active_q;             // set by first redirect
  logic                hold_valid_q, hold_valid_d;
  fetch_rsp_t          hold_q;
  logic [1:0]          discard_q, discard_d; // stale responses still to come

  logic stale_rvalid;
  logic live_rvalid;
  logic live_pending;
  logic accept;
  logic capture;

  assign stale_rvalid = instr_rvalid_i & (discard_q != 2'd0);
  assign live_rvalid  = instr_rvalid_i & (discard_q == 2'd0) & (state_q == FS_WAIT);
  assign accept       = hold_valid_q & ready_i;
  assign capture      = live_rvalid & ~redirect_i.valid;

  // granted request whose answer a redirect now turns stale
  assign live_pending = ((state_q == FS_WAIT) & ~live_rvalid) |
                        ((state_q == FS_REQ) & instr_gnt_i);

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d      = state_q;
    addr_d       = addr_q;
    hold_valid_d = hold_valid_q;
    discard_d    = discard_q - {1'b0, stale_rvalid};

    if (redirect_i.valid) begin
      addr_d       = redirect_i.addr;
      hold_valid_d = 1'b0;             // held word is from the old stream
      discard_d    = discard_d + {1'b0, live_pending};
      // an ungranted request stays on the bus, now with the new address
      if (req_i || (instr_req_o && !instr_gnt_i)) begin
        state_d = FS_REQ;
      end else begin
        state_d = FS_IDLE;
      end
    end else begin
      case (state_q)
        FS_IDLE: begin
          if (accept) begin
            hold_valid_d = 1'b0;
            addr_d       = addr_q + `IF_XLEN'(`IF_FETCH_STEP);
          end
          // holder free or freed this cycle
          if (active_q && req_i && (!hold_valid_q || ready_i)) begin
            state_d = FS_REQ;
          end
        end
        FS_REQ: begin
          if (instr_gnt_i) begin
            state_d = FS_WAIT;
          end
        end
        FS_WAIT: begin
          if (capture) begin
            hold_valid_d = 1'b1;
            state_d      = FS_IDLE;
          end
        end
        default: state_d = FS_IDLE;
      endcase
    end
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FS_IDLE;
      active_q     <= 1'b0;
      hold_valid_q <= 1'b0;
      discard_q    <= 2'd0;
    end else begin
      state_q      <= state_d;
      active_q     <= active_q | redirect_i.valid;
      hold_valid_q <= hold_valid_d;
      discard_q    <= discard_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    if (capture) begin
      hold_q.rdata <= instr_rdata_i;
      hold_q.addr  <= addr_q;
      hold_q.err   <= instr_err_i;  // bus error travels with the word
    end
  end

  assign instr_req_o  = (state_q == FS_REQ);
  assign instr_addr_o = addr_q;
  assign valid_o      = hold_valid_q;
  assign rsp_o        = hold_q;
  assign busy_o       = (state_q != FS_IDLE) | (discard_q != 2'd0);

endmodule

// File: hdl/pc_select.sv
/*
  Next PC selection
  builds the exception vector, picks the next fetch address and
  flags mtvec initialisation on boot
*/

`timescale 1ns/1ps

`include "if_params.svh"

module pc_select import if_pkg::*; (
  input  logic [`IF_XLEN-1:0] boot_addr_i,
  input  logic [`IF_XLEN-1:0] csr_mtvec_i,
  input  logic [`IF_XLEN-1:0] csr_mepc_i,
  input  logic [`IF_XLEN-1:0] csr_depc_i,
  input  logic [`IF_XLEN-1:0] branch_target_i,
  input  logic [4:0]          irq_id_i,
  input  pc_sel_e             pc_mux_i,
  input  exc_pc_sel_e         exc_pc_mux_i,
  input  logic                pc_set_i,
  output redirect_t           redirect_o,
  output logic                csr_mtvec_init_o
);

  logic [`IF_XLEN-1:0] vec_base;
  logic [`IF_XLEN-1:0] boot_pc;
  logic [`IF_XLEN-1:0] exc_pc;
  logic [`IF_XLEN-1:0] next_pc;

  // mtvec with the mode and low bits dropped
  assign vec_base = {csr_mtvec_i[`IF_XLEN-1:`IF_VEC_ALIGN_BITS], {`IF_VEC_ALIGN_BITS{1'b0}}};
  assign boot_pc  = {boot_addr_i[`IF_XLEN-1:`IF_VEC_ALIGN_BITS], `IF_BOOT_OFFSET};

  ////////////////////
  // exception vector
  ////////////////////

  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = vec_base;
      EXC_PC_IRQ:     exc_pc = vec_base | `IF_XLEN'({irq_id_i, 2'b00}); // one word per irq
      EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
      default:        exc_pc = vec_base;
    endcase
  end

  ////////////////////
  // next fetch address
  ////////////////////

  always_comb begin
    case (pc_mux_i)
      PC_BOOT: next_pc = boot_pc;
      PC_JUMP: next_pc = branch_target_i;
      PC_EXC:  next_pc = exc_pc;
      PC_ERET: next_pc = csr_mepc_i;  // back from trap
      PC_DRET: next_pc = csr_depc_i;  // back from debug mode
      default: next_pc = boot_pc;
    endcase
  end

  // fetches are whole words only
  assign redirect_o.valid = pc_set_i;
  assign redirect_o.addr  = {next_pc[`IF_XLEN-1:2], 2'b00};

  // CSR file loads mtvec from the boot address
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// File: hdl/if_pkg.sv
/*
  Instruction fetch package
  selector enums, fetch state and the structs passed between blocks
*/

`include "if_params.svh"

package if_pkg;

  // next PC source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception vector source
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // fetch unit bus state
  typedef enum logic [1:0] {
    FS_IDLE = 2'd0,
    FS_REQ  = 2'd1,
    FS_WAIT = 2'd2
  } fetch_state_e;

  // one fetched word on its way to IF-ID
  typedef struct packed {
    logic [`IF_XLEN-1:0] rdata;
    logic [`IF_XLEN-1:0] addr;
    logic                err;
  } fetch_rsp_t;

  typedef struct packed {
    logic                valid; // restart fetching
    logic [`IF_XLEN-1:0] addr;  // word aligned
  } redirect_t;

endpackage

// File: include/if_params.svh
/*
  Instruction fetch stage constants
  widths, debug entry points and boot and vector address shaping
*/

`ifndef IF_PARAMS_SVH
`define IF_PARAMS_SVH

// address and instruction width
`define IF_XLEN 32

// debug module entry points
`define IF_DM_HALT_ADDR 32'h1A11_0800
`define IF_DM_EXC_ADDR  32'h1A11_0808

// low byte of the boot PC
`define IF_BOOT_OFFSET 8'h80

// low bits of mtvec and boot address that get replaced
`define IF_VEC_ALIGN_BITS 8

// byte step between sequential fetches
`define IF_FETCH_STEP 4

`endif
